// File: hdl/iobPkg.sv
`default_nettype none

package iobPkg;

	// ****************************************
	// bus widths
	// ****************************************

	localparam int regionWidth = 3; // top address bits that pick the address space.
	localparam int devWidth = 4;
	localparam int ioAddrWidth = 20; // device number above a 16-bit register index.
	localparam int addrWidth = regionWidth + ioAddrWidth; // word address A23..A1.
	localparam int dataWidth = 16;
	localparam int laneWidth = 2; // upper byte in bit 1, lower byte in bit 0.

	// ****************************************
	// address decode
	// ****************************************

	localparam logic [regionWidth-1:0] ioRegion = 3'b110;

	// writes to these devices may complete on the FSB before the device sees them.
	localparam logic [devWidth-1:0] postedDevFirst = 4'h8;
	localparam logic [devWidth-1:0] postedDevLast = 4'hb;

	// device acknowledge timeout, in clock cycles after the strobe.
	localparam int ackTimeout = 64;
	localparam int ackCountWidth = $clog2(ackTimeout);
	localparam logic [ackCountWidth-1:0] ackLast = ackCountWidth'(ackTimeout - 1);

	// posting machine of the bus-side slave.
	localparam logic [1:0] slvIdle = 2'd0;
	localparam logic [1:0] slvLoad = 2'd1;
	localparam logic [1:0] slvReq = 2'd2;
	localparam logic [1:0] slvRelease = 2'd3;

	// device cycle of the I/O bus master.
	localparam logic [1:0] mstIdle = 2'd0;
	localparam logic [1:0] mstBusy = 2'd1;
	localparam logic [1:0] mstDone = 2'd2;

endpackage

`default_nettype wire

// File: hdl/fsbDecode.sv
`timescale 1ns/1ps
`default_nettype none

module fsbDecode (
	input logic CLK,
	input logic reset,
	input logic nAs,
	input logic nWe,
	input logic [iobPkg::addrWidth-1:0] addr,
	output logic busActive,
	output logic ioSel,
	output logic postSel
);

	logic [iobPkg::regionWidth-1:0] region;
	logic [iobPkg::devWidth-1:0] device;
	logic devPosted;

	assign region = addr[iobPkg::addrWidth-1 -: iobPkg::regionWidth];
	assign device = addr[iobPkg::ioAddrWidth-1 -: iobPkg::devWidth];

	// the strobe is taken through one flop, and the slave qualifies every
	// bus cycle with the registered copy.
	always_ff @(posedge CLK) begin
		if (reset) begin
			busActive <= 1'b0;
		end else begin
			busActive <= ~nAs;
		end
	end

	assign ioSel = (region == iobPkg::ioRegion); // address only, like the chip select.

	assign devPosted = (device >= iobPkg::postedDevFirst) &&
		(device <= iobPkg::postedDevLast);

	// reads are never posted.
	assign postSel = ioSel && ~nWe && devPosted;

endmodule

`default_nettype wire

// File: hdl/iobSlave.sv
`timescale 1ns/1ps
`default_nettype none

module iobSlave (
	input logic CLK,
	input logic reset,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	input logic nAs,
	input logic busActive,
	input logic ioSel,
	input logic postSel,
	output logic ready,
	output logic nBerr,
	output logic dataOe,
	output logic ioReq,
	output logic ioWrite,
	output logic [iobPkg::laneWidth-1:0] ioLanes,
	output logic latchLoad0,
	output logic latchLoad1,
	output logic useLevel1,
	input logic ioActive,
	input logic ioBusErr
);

	logic [1:0] state;
	logic once; // set when the current FSB cycle has been queued.
	logic ioActiveSync;
	logic newCycle;
	logic take0;
	logic take1;
	logic level1Full;
	logic write1;
	logic [iobPkg::laneWidth-1:0] lanes1;
	logic drained;
	logic ioReady;

	always_ff @(posedge CLK) begin
		if (reset) begin
			ioActiveSync <= 1'b0;
		end else begin
			ioActiveSync <= ioActive;
		end
	end

	assign dataOe = ~nAs && ioSel && nWe; // read data drives the FSB for the whole strobe.

	// ****************************************
	// queue capture
	// ****************************************

	// a fresh cycle goes straight into level 0 when the machine is idle,
	// otherwise into level 1 if that is free.
	assign newCycle = busActive && ioSel && ~once;
	assign take0 = newCycle && (state == iobPkg::slvIdle) && ~level1Full;
	assign take1 = newCycle && (state != iobPkg::slvIdle) && ~level1Full;

	// level 1 moves down to level 0 in the load state.
	assign latchLoad0 = take0 || ((state == iobPkg::slvLoad) && level1Full);
	assign latchLoad1 = take1;
	assign useLevel1 = (state == iobPkg::slvLoad);

	always_ff @(posedge CLK) begin
		if (reset) begin
			level1Full <= 1'b0;
		end else if (take1) begin
			level1Full <= 1'b1;
		end else if (state == iobPkg::slvLoad) begin
			level1Full <= 1'b0; // its contents went to level 0 on this edge.
		end
	end

	always_ff @(posedge CLK) begin
		if (take1) begin
			write1 <= ~nWe;
			lanes1 <= {~nUds, ~nLds};
		end
	end

	// ****************************************
	// posting machine
	// ****************************************

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= iobPkg::slvIdle;
			ioReq <= 1'b0;
		end else begin
			case (state)
				iobPkg::slvIdle: begin
					if (level1Full || take0) begin // the second level has priority.
						state <= iobPkg::slvLoad;
						ioReq <= 1'b1;
					end
				end
				iobPkg::slvLoad: state <= iobPkg::slvReq;
				iobPkg::slvReq: begin
					if (ioActiveSync) begin
						state <= iobPkg::slvRelease;
						ioReq <= 1'b0;
					end
				end
				iobPkg::slvRelease: begin
					if (~ioActiveSync) state <= iobPkg::slvIdle; // master has finished.
				end
				default: state <= iobPkg::slvIdle;
			endcase
		end
	end

	// direction and lanes of level 0 travel with the request.
	always_ff @(posedge CLK) begin
		if (state == iobPkg::slvIdle) begin
			if (level1Full) begin
				ioWrite <= write1;
				ioLanes <= lanes1;
			end else if (take0) begin
				ioWrite <= ~nWe;
				ioLanes <= {~nUds, ~nLds};
			end
		end
	end

	// ****************************************
	// FSB termination
	// ****************************************

	always_ff @(posedge CLK) begin
		if (reset || ~busActive) begin
			once <= 1'b0;
		end else if (take0 || take1) begin
			once <= 1'b1;
		end
	end

	// with nothing left in either level and the master idle, the error flag
	// belongs to the cycle the FSB is waiting on.
	assign drained = ((state == iobPkg::slvIdle) || (state == iobPkg::slvRelease)) &&
		~ioActiveSync && ~level1Full;

	always_ff @(posedge CLK) begin
		if (reset || nAs) begin
			ioReady <= 1'b0;
			nBerr <= 1'b1;
		end else if (busActive && once && ~postSel && drained) begin
			ioReady <= ~ioBusErr;
			nBerr <= ~ioBusErr;
		end
	end

	// a posted write is done as soon as it sits in the queue.
	assign ready = ~ioSel || ioReady || (postSel && once && busActive);

endmodule

`default_nettype wire

// File: hdl/iobLatch.sv
`timescale 1ns/1ps
`default_nettype none

module iobLatch (
	input logic CLK,
	input logic reset,
	input logic [iobPkg::addrWidth-1:0] addr,
	input logic [iobPkg::dataWidth-1:0] dataIn,
	input logic latchLoad0,
	input logic latchLoad1,
	input logic useLevel1,
	output logic [iobPkg::ioAddrWidth-1:0] ioAddr,
	output logic [iobPkg::dataWidth-1:0] ioWData
);

	logic [iobPkg::ioAddrWidth-1:0] addr1;
	logic [iobPkg::dataWidth-1:0] data1;
	logic [iobPkg::ioAddrWidth-1:0] addrNext;
	logic [iobPkg::dataWidth-1:0] dataNext;

	// ****************************************
	// level 1
	// ****************************************

	// the region bits are dropped here since the device bus never sees them.
	always_ff @(posedge CLK) begin
		if (latchLoad1) begin
			addr1 <= addr[iobPkg::ioAddrWidth-1:0];
			data1 <= dataIn;
		end
	end

	// ****************************************
	// level 0
	// ****************************************

	assign addrNext = useLevel1 ? addr1 : addr[iobPkg::ioAddrWidth-1:0];
	assign dataNext = useLevel1 ? data1 : dataIn;

	// level 0 drives the device bus directly.
	always_ff @(posedge CLK) begin
		if (reset) begin
			ioAddr <= '0; // the device bus idles at address zero.
			ioWData <= '0;
		end else if (latchLoad0) begin
			ioAddr <= addrNext;
			ioWData <= dataNext;
		end
	end

endmodule

`default_nettype wire

// File: hdl/iobMaster.sv
`timescale 1ns/1ps
`default_nettype none

module iobMaster (
	input logic CLK,
	input logic reset,
	input logic ioReq,
	input logic ioWrite,
	input logic [iobPkg::laneWidth-1:0] ioLanes,
	output logic ioActive,
	output logic ioBusErr,
	output logic ioStrobe,
	output logic ioWriteOut,
	output logic [iobPkg::laneWidth-1:0] ioLanesOut,
	input logic ioAck,
	input logic [iobPkg::dataWidth-1:0] ioRData,
	output logic [iobPkg::dataWidth-1:0] readData
);

	logic reqSync;
	logic [1:0] state;
	logic [iobPkg::ackCountWidth-1:0] waitCount; // cycles spent waiting for the ack.
	logic timedOut;
	logic startCycle;

	always_ff @(posedge CLK) begin
		if (reset) begin
			reqSync <= 1'b0;
		end else begin
			reqSync <= ioReq;
		end
	end

	assign startCycle = (state == iobPkg::mstIdle) && reqSync;
	assign timedOut = (waitCount == iobPkg::ackLast);

	// ****************************************
	// device cycle
	// ****************************************

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= iobPkg::mstIdle;
			ioActive <= 1'b0;
			ioBusErr <= 1'b0;
			ioStrobe <= 1'b0;
			waitCount <= '0;
		end else begin
			ioStrobe <= 1'b0; // single-cycle strobe.
			case (state)
				iobPkg::mstIdle: begin
					if (reqSync) begin
						state <= iobPkg::mstBusy;
						ioActive <= 1'b1;
						ioBusErr <= 1'b0;
						ioStrobe <= 1'b1;
						waitCount <= '0;
					end
				end
				iobPkg::mstBusy: begin
					if (ioAck) begin
						state <= iobPkg::mstDone;
						ioActive <= 1'b0;
					end else if (timedOut) begin
						// nobody answered, so the cycle ends with an error.
						state <= iobPkg::mstDone;
						ioActive <= 1'b0;
						ioBusErr <= 1'b1;
					end else begin
						waitCount <= waitCount + 1'b1;
					end
				end
				iobPkg::mstDone: begin
					// wait for the slave to drop its request before the next one.
					if (~reqSync) state <= iobPkg::mstIdle;
				end
				default: state <= iobPkg::mstIdle;
			endcase
		end
	end

	// ****************************************
	// payload
	// ****************************************

	always_ff @(posedge CLK) begin
		if (startCycle) begin
			ioWriteOut <= ioWrite;
			ioLanesOut <= ioLanes;
		end
	end

	// read data is held here until the FSB has taken it.
	always_ff @(posedge CLK) begin
		if ((state == iobPkg::mstBusy) && ioAck && ~ioWriteOut) begin
			readData <= ioRData;
		end
	end

endmodule

`default_nettype wire

// File: hdl/iobBridge.sv
`timescale 1ns/1ps
`default_nettype none

module iobBridge (
	input logic CLK,
	input logic reset,
	input logic nAs,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	input logic [iobPkg::addrWidth-1:0] addr,
	input logic [iobPkg::dataWidth-1:0] dataIn,
	output logic [iobPkg::dataWidth-1:0] dataOut,
	output logic dataOe,
	output logic ready,
	output logic nBerr,
	output logic [iobPkg::ioAddrWidth-1:0] ioAddr,
	output logic [iobPkg::dataWidth-1:0] ioWData,
	output logic ioStrobe,
	output logic ioWrite,
	output logic [iobPkg::laneWidth-1:0] ioLanes,
	input logic ioAck,
	input logic [iobPkg::dataWidth-1:0] ioRData
);

	logic busActive;
	logic ioSel;
	logic postSel;
	logic ioReq;
	logic reqWrite; // direction and lanes on their way from the slave to the master.
	logic [iobPkg::laneWidth-1:0] reqLanes;
	logic ioActive;
	logic ioBusErr;
	logic latchLoad0;
	logic latchLoad1;
	logic useLevel1;

	fsbDecode decode (
		.CLK(CLK), .reset(reset), .nAs(nAs), .nWe(nWe), .addr(addr),
		.busActive(busActive), .ioSel(ioSel), .postSel(postSel)
	);

	iobSlave slave (
		.CLK(CLK), .reset(reset), .nWe(nWe), .nLds(nLds), .nUds(nUds), .nAs(nAs),
		.busActive(busActive), .ioSel(ioSel), .postSel(postSel),
		.ready(ready), .nBerr(nBerr), .dataOe(dataOe),
		.ioReq(ioReq), .ioWrite(reqWrite), .ioLanes(reqLanes),
		.latchLoad0(latchLoad0), .latchLoad1(latchLoad1), .useLevel1(useLevel1),
		.ioActive(ioActive), .ioBusErr(ioBusErr)
	);

	iobLatch latch (
		.CLK(CLK), .reset(reset), .addr(addr), .dataIn(dataIn),
		.latchLoad0(latchLoad0), .latchLoad1(latchLoad1), .useLevel1(useLevel1),
		.ioAddr(ioAddr), .ioWData(ioWData)
	);

	// the master's read register feeds the FSB data output directly.
	iobMaster master (
		.CLK(CLK), .reset(reset), .ioReq(ioReq), .ioWrite(reqWrite), .ioLanes(reqLanes),
		.ioActive(ioActive), .ioBusErr(ioBusErr), .ioStrobe(ioStrobe),
		.ioWriteOut(ioWrite), .ioLanesOut(ioLanes),
		.ioAck(ioAck), .ioRData(ioRData), .readData(dataOut)
	);

endmodule

`default_nettype wire

// File: bench/iobBridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module iobSlaveChecks (
	input logic CLK,
	input logic reset,
	input logic ioReq,
	input logic ioActiveSync,
	input logic latchLoad0,
	input logic latchLoad1,
	input logic nBerr,
	input logic busActive
);

	int failCount = 0;

	// ****************************************
	// request handshake and queue
	// ****************************************

	reqHeld: assert property (@(posedge CLK) disable iff (reset)
		ioReq && !ioActiveSync |=> ioReq)
		else begin
			$error("ioReq dropped before ioActive was seen");
			failCount++;
		end

	oneLoad: assert property (@(posedge CLK) disable iff (reset)
		!(latchLoad0 && latchLoad1))
		else begin
			$error("both latch enables high in the same clock");
			failCount++;
		end

	berrInCycle: assert property (@(posedge CLK) disable iff (reset)
		!nBerr |-> busActive) // a bus error belongs to a live FSB cycle.
		else begin
			$error("nBerr low outside an FSB cycle");
			failCount++;
		end

endmodule

bind iobSlave iobSlaveChecks checks (
	.CLK(CLK), .reset(reset), .ioReq(ioReq), .ioActiveSync(ioActiveSync),
	.latchLoad0(latchLoad0), .latchLoad1(latchLoad1), .nBerr(nBerr), .busActive(busActive)
);

`default_nettype wire

// File: bench/iobBridgeTb.sv
`timescale 1ns/1ps
`default_nettype none

module iobBridgeTb;

	// one FSB cycle and what it must produce.
	typedef struct packed {
		logic write;
		logic [iobPkg::devWidth-1:0] dev;
		logic [15:0] regIdx;
		logic [iobPkg::dataWidth-1:0] data;
		logic [iobPkg::laneWidth-1:0] lanes;
		logic [7:0] latency; // device clocks from strobe to ack.
		logic useShadow; // expected read data is whatever the device memory holds.
		logic [iobPkg::dataWidth-1:0] expData;
		logic expErr;
		logic [3:0] expLag; // writes not yet acknowledged when the FSB cycle ends.
	} cycleEntry;

	localparam int numTests = 15;
	localparam int cycleLimit = numTests * (iobPkg::ackTimeout + 40) + 16;

	logic CLK, reset, nAs, nWe, nLds, nUds;
	logic [iobPkg::addrWidth-1:0] addr;
	logic [iobPkg::dataWidth-1:0] dataIn, dataOut, ioWData, ioRData;
	logic dataOe, ready, nBerr, ioStrobe, ioWrite, ioAck;
	logic [iobPkg::ioAddrWidth-1:0] ioAddr;
	logic [iobPkg::laneWidth-1:0] ioLanes;

	cycleEntry cycles [numTests];
	cycleEntry pending [$]; // started on the FSB, not yet strobed on the device bus.
	logic [iobPkg::dataWidth-1:0] shadow [logic [iobPkg::ioAddrWidth-1:0]];
	int seed = 32'h4dac;
	int errors = 0;
	int writesIssued = 0;
	int writesAcked = 0;
	int cycleCount = 0;

	iobBridge dut (
		.CLK(CLK), .reset(reset), .nAs(nAs), .nWe(nWe), .nLds(nLds), .nUds(nUds),
		.addr(addr), .dataIn(dataIn), .dataOut(dataOut), .dataOe(dataOe),
		.ready(ready), .nBerr(nBerr), .ioAddr(ioAddr), .ioWData(ioWData),
		.ioStrobe(ioStrobe), .ioWrite(ioWrite), .ioLanes(ioLanes),
		.ioAck(ioAck), .ioRData(ioRData)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ****************************************
	// helpers
	// ****************************************

	// untouched device words read back as a mix of every address bit.
	function automatic logic [15:0] fillWord(input logic [19:0] a);
		fillWord = a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a5a;
	endfunction

	function automatic logic [15:0] laneMask(input logic [1:0] lanes);
		laneMask = {{8{lanes[1]}}, {8{lanes[0]}}};
	endfunction

	function automatic logic [15:0] shadowWord(input logic [19:0] a);
		if (shadow.exists(a)) shadowWord = shadow[a];
		else shadowWord = fillWord(a);
	endfunction

	task automatic flagError(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		errors++;
	endtask

	// runs one FSB cycle, starting and ending just after a rising edge.
	task automatic runCycle(input int idx);
		cycleEntry c;
		int errorsBefore;
		logic [15:0] expected, mask;
		c = cycles[idx];
		errorsBefore = errors;
		mask = laneMask(c.lanes);
		pending.push_back(c);
		if (c.write) writesIssued++;
		addr = {iobPkg::ioRegion, c.dev, c.regIdx};
		nWe = ~c.write;
		nUds = ~c.lanes[1];
		nLds = ~c.lanes[0];
		dataIn = c.write ? c.data : 16'($random(seed));
		nAs = 1'b0;
		@(negedge CLK);
		while (!ready && nBerr) @(negedge CLK); // a bus error ends the cycle too.
		if (ready !== !c.expErr || nBerr !== !c.expErr) begin
			flagError($sformatf("test %0d ended with ready %b nBerr %b", idx, ready, nBerr));
		end
		if (dataOe !== !c.write) begin
			flagError($sformatf("test %0d dataOe %b", idx, dataOe));
		end
		if (writesIssued - writesAcked != int'(c.expLag)) begin
			flagError($sformatf("test %0d ended with %0d writes unacknowledged, expected %0d",
				idx, writesIssued - writesAcked, c.expLag));
		end
		expected = c.useShadow ? shadowWord({c.dev, c.regIdx}) : c.expData;
		if (!c.write && !c.expErr && ((dataOut ^ expected) & mask) != 16'h0) begin
			flagError($sformatf("test %0d dataOut %h, expected %h", idx,
				dataOut & mask, expected & mask));
		end
		@(posedge CLK);
		#5;
		nAs = 1'b1;
		nWe = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		@(posedge CLK); // one idle clock between cycles.
		#5;
		$display("test %0d %s dev %h reg %h lanes %b: %s", idx, c.write ? "write" : "read",
			c.dev, c.regIdx, c.lanes, (errors == errorsBefore) ? "ok" : "wrong");
	endtask

	// ****************************************
	// device model
	// ****************************************

	initial begin : deviceModel
		cycleEntry c;
		logic [19:0] a;
		logic [15:0] wdata, mask;
		ioAck = 1'b0;
		ioRData = 16'h0;
		forever begin
			@(posedge CLK);
			#5;
			if (ioStrobe && pending.size() == 0) begin
				flagError("device strobe with no FSB cycle outstanding");
			end else if (ioStrobe) begin
				c = pending.pop_front();
				a = ioAddr;
				wdata = ioWData;
				mask = laneMask(ioLanes);
				if (a !== {c.dev, c.regIdx} || ioWrite !== c.write || ioLanes !== c.lanes ||
					(c.write && wdata !== c.data)) begin
					flagError($sformatf("device cycle %h write %b data %h lanes %b, expected %h",
						a, ioWrite, wdata, ioLanes, {c.dev, c.regIdx}));
				end
				if (c.dev != 4'hf) begin // device 15 is absent and never answers.
					repeat (c.latency) begin
						@(posedge CLK);
						#5;
					end
					if (c.write) begin
						shadow[a] = (shadowWord(a) & ~mask) | (wdata & mask);
						writesAcked++;
					end
					ioRData = (shadowWord(a) & mask) | (16'($random(seed)) & ~mask);
					ioAck = 1'b1;
					@(posedge CLK);
					#5;
					ioAck = 1'b0;
				end
			end
		end
	end

	// ****************************************
	// stimulus
	// ****************************************

	initial begin
		int failures;
		reset = 1'b1;
		nAs = 1'b1;
		nWe = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		addr = '0;
		dataIn = '0;
		// devices 8 to 11 take posted writes.
		//              wr    dev   reg     data      lanes  lat   shadow expData   err   lag
		cycles[0]  = '{1'b0, 4'h2, 16'h10, 16'h0000, 2'b11, 8'd3, 1'b1, 16'h0000, 1'b0, 4'd0};
		cycles[1]  = '{1'b1, 4'h2, 16'h10, 16'h1234, 2'b11, 8'd4, 1'b0, 16'h0000, 1'b0, 4'd0};
		cycles[2]  = '{1'b0, 4'h2, 16'h10, 16'h0000, 2'b11, 8'd1, 1'b0, 16'h1234, 1'b0, 4'd0};
		cycles[3]  = '{1'b1, 4'h3, 16'h20, 16'h0f0f, 2'b11, 8'd2, 1'b0, 16'h0000, 1'b0, 4'd0};
		cycles[4]  = '{1'b1, 4'h3, 16'h20, 16'ha5c3, 2'b10, 8'd3, 1'b0, 16'h0000, 1'b0, 4'd0};
		cycles[5]  = '{1'b1, 4'h3, 16'h20, 16'h7e81, 2'b01, 8'd2, 1'b0, 16'h0000, 1'b0, 4'd0};
		cycles[6]  = '{1'b0, 4'h3, 16'h20, 16'h0000, 2'b11, 8'd2, 1'b0, 16'ha581, 1'b0, 4'd0};
		cycles[7]  = '{1'b0, 4'h3, 16'h20, 16'h0000, 2'b10, 8'd1, 1'b0, 16'ha581, 1'b0, 4'd0};
		cycles[8]  = '{1'b1, 4'h8, 16'h01, 16'h1111, 2'b11, 8'd6, 1'b0, 16'h0000, 1'b0, 4'd1};
		cycles[9]  = '{1'b1, 4'h9, 16'h02, 16'h2222, 2'b11, 8'd5, 1'b0, 16'h0000, 1'b0, 4'd2};
		cycles[10] = '{1'b1, 4'ha, 16'h03, 16'h3333, 2'b01, 8'd2, 1'b0, 16'h0000, 1'b0, 4'd2};
		cycles[11] = '{1'b0, 4'ha, 16'h03, 16'h0000, 2'b11, 8'd2, 1'b1, 16'h0000, 1'b0, 4'd0};
		cycles[12] = '{1'b0, 4'hf, 16'h00, 16'h0000, 2'b11, 8'd0, 1'b0, 16'h0000, 1'b1, 4'd0};
		cycles[13] = '{1'b0, 4'h8, 16'h01, 16'h0000, 2'b11, 8'd2, 1'b0, 16'h1111, 1'b0, 4'd0};
		cycles[14] = '{1'b0, 4'h9, 16'h02, 16'h0000, 2'b01, 8'd1, 1'b0, 16'h2222, 1'b0, 4'd0};
		repeat (16) @(posedge CLK);
		#5;
		reset = 1'b0;
		@(posedge CLK);
		#5;
		for (int i = 0; i < numTests; i++) runCycle(i);
		if (pending.size() != 0) begin
			$display("the device bus never saw %0d of the FSB cycles", pending.size());
			errors++;
		end
		failures = errors + dut.slave.checks.failCount;
		$display("%0d tests run, %0d checks failed", numTests, failures);
		if (failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/iobPkg.sv
hdl/fsbDecode.sv
hdl/iobSlave.sv
hdl/iobLatch.sv
hdl/iobMaster.sv
hdl/iobBridge.sv
bench/iobBridge_sva.sv
bench/iobBridgeTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module iobBridgeTb -o iobSim &&
	./obj_dir/iobSim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TESTS PASSED" &&
	echo "simulation run ok" ||
	{ echo "simulation run not ok"; exit 1; }
